//--- filelist.f
hdl/fpu_pkg.sv
hdl/fpu_op_decode.sv
hdl/fpu_issue_fsm.sv
hdl/fpu_hold_buffer.sv
hdl/fpu_latency_timer.sv
hdl/fpu_noncomp_unit.sv
hdl/fpu_wrap.sv
tb/fpu_clk_gen.sv
tb/fpu_wrap_chk.sv
tb/fpu_wrap_tb.sv

//--- tb/fpu_wrap_tb.sv
module fpu_wrap_tb
    import fpu_pkg::*;
();

    localparam int WAIT_LIMIT = 60;  // Cycles before any wait gives up

    logic      clk, rst_n, flush, fpu_valid, fpu_ready, nv, out_valid;
    fu_op_e    fpu_op;
    rm_t       fpu_rm;
    fp32_t     operand_a, operand_b, result;
    trans_id_t trans_id, out_tag, next_tag;
    logic [31:0] rng = 32'd6;        // xorshift state
    int        cycle_cnt = 0;        // Rising edges seen
    int        value_errs = 0, proto_errs = 0, timeouts = 0;
    fpu_rsp_t  exp_q[$];             // Expected responses in issue order
    string     name_q[$];
    int        sent_q[$];            // Edge count at drive time
    bit        timed_q[$];           // Sent with the unit idle

    // One value per class, in RISC-V class mask order
    fp32_t specials [10] = '{32'hFF80_0000, 32'hBF80_0000, 32'h8000_0010, 32'h8000_0000,
                             32'h0000_0000, 32'h0000_0001, 32'h4049_0FDB, 32'h7F80_0000,
                             32'h7FA0_0000, 32'h7FC0_0001};

    fpu_clk_gen i_clk_gen (.clk_o(clk), .rst_no(rst_n));

    fpu_wrap fpu_wrap_i (
        .clk_i (clk), .rst_ni (rst_n), .flush_i (flush),
        .fpu_valid_i (fpu_valid), .fpu_ready_o (fpu_ready), .fpu_op_i (fpu_op),
        .fpu_rm_i (fpu_rm), .operand_a_i (operand_a), .operand_b_i (operand_b),
        .trans_id_i (trans_id), .result_o (result), .fpu_trans_id_o (out_tag),
        .fpu_nv_o (nv), .fpu_valid_o (out_valid)
    );

    always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

    // ----------------------------------------
    // Stimulus helpers and reference
    // ----------------------------------------
    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    function automatic fp32_t pick_operand();
        rng = xorshift(rng);
        if (rng[2:0] == 3'd0) return specials[rng[31:28] % 10];  // Some special values
        return rng;
    endfunction

    // Issue fields to unit request, per the op mapping
    function automatic fpu_req_t build_req(fu_op_e op, rm_t rm, fp32_t a, fp32_t b,
                                           trans_id_t tag);
        fpu_req_t r;
        r = '{op: SGNJ, sub_op: 2'd3, operand_a: a, operand_b: b, tag: tag};  // Moves
        if (op == FSGNJ || op == FMIN_MAX || op == FCMP || op == FCLASS)
            r.sub_op = rm[1:0];  // Low rounding bits pick the sub-op
        if (op == FMIN_MAX) r.op = MINMAX;
        if (op == FCMP)     r.op = CMP;
        if (op == FCLASS)   r.op = CLASSIFY;
        return r;
    endfunction

    function automatic logic [9:0] class_of(input fp32_t x);
        if (x[30:23] == 8'hFF && x[22:0] != 0) return x[22] ? 10'h200 : 10'h100;
        if (x[30:23] == 8'hFF) return x[31] ? 10'h001 : 10'h080;         // Infinities
        if (x[30:23] == 8'h00 && x[22:0] == 0) return x[31] ? 10'h008 : 10'h010;
        if (x[30:23] == 8'h00) return x[31] ? 10'h004 : 10'h020;         // Subnormals
        return x[31] ? 10'h002 : 10'h040;
    endfunction

    // Sign flipped for positives, all bits flipped for negatives, -0 ends below +0
    function automatic logic [31:0] order_key(input fp32_t x);
        return x[31] ? ~x : (x ^ 32'h8000_0000);
    endfunction

    function automatic fpu_rsp_t ref_model(input fpu_req_t req);
        fpu_rsp_t rsp;
        fp32_t    a, b;
        logic     a_nan, b_nan, snan, zeros, eq, lt;
        a     = req.operand_a;
        b     = req.operand_b;
        a_nan = class_of(a) >= 10'h100;
        b_nan = class_of(b) >= 10'h100;
        snan  = class_of(a) == 10'h100 || class_of(b) == 10'h100;
        zeros = (class_of(a) & 10'h018) != 0 && (class_of(b) & 10'h018) != 0;
        eq    = !a_nan && !b_nan && (a == b || zeros);
        lt    = !a_nan && !b_nan && !zeros && order_key(a) < order_key(b);
        rsp   = '{result: a, tag: req.tag, nv: 1'b0};
        case (req.op)
            SGNJ: begin
                if (req.sub_op == 2'd0) rsp.result[31] = b[31];
                if (req.sub_op == 2'd1) rsp.result[31] = !b[31];
                if (req.sub_op == 2'd2) rsp.result[31] = a[31] ^ b[31];
            end
            MINMAX: begin
                rsp.nv = snan;
                if (a_nan && b_nan) rsp.result = CANON_NAN;
                else if (a_nan) rsp.result = b;
                else if (!b_nan && req.sub_op == 2'd0)
                    rsp.result = (order_key(a) <= order_key(b)) ? a : b;
                else if (!b_nan && req.sub_op == 2'd1)
                    rsp.result = (order_key(a) >= order_key(b)) ? a : b;
            end
            CMP: begin
                rsp.result = '0;
                if (req.sub_op == 2'd0) rsp.result[0] = lt || eq;
                if (req.sub_op == 2'd1) rsp.result[0] = lt;
                if (req.sub_op == 2'd2) rsp.result[0] = eq;
                if (req.sub_op < 2'd2) rsp.nv = a_nan || b_nan;   // Signalling compares
                if (req.sub_op == 2'd2) rsp.nv = snan;
            end
            default: rsp.result = {22'b0, class_of(a)};
        endcase
        return rsp;
    endfunction

    task automatic finish_run();
        int chk_errs;
        chk_errs = fpu_wrap_i.i_wrap_chk.fail_cnt;
        assert (exp_q.size() == 0) else begin
            proto_errs++;
            $display("%0d expected results never came back", exp_q.size());
        end
        $display("Errors: value %0d, protocol %0d, timeout %0d, assertion %0d",
                 value_errs, proto_errs, timeouts, chk_errs);
        if (value_errs + proto_errs + timeouts + chk_errs == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    endtask

    // Waits for a cycle with ready high, then drives one request
    task automatic issue(fu_op_e op, rm_t rm, fp32_t a, fp32_t b, string name);
        int waited;
        waited = 0;
        @(negedge clk);
        while (!fpu_ready) begin
            @(posedge clk);
            #5;
            fpu_valid = 1'b0;
            // Scramble the live fields so only the held copy matches
            fpu_rm    = fpu_rm + 3'd1;
            operand_a = operand_a + 32'h1357_9BDF;
            operand_b = operand_b + 32'h2468_ACE1;
            trans_id  = trans_id + 3'd1;
            waited++;
            if (waited > WAIT_LIMIT) begin
                timeouts++;
                $display("Timeout: issue side never saw ready for %s", name);
                finish_run();
            end
            @(negedge clk);
        end
        @(posedge clk);
        #5;
        timed_q.push_back(exp_q.size() == 0);  // Nothing outstanding, unit idle
        sent_q.push_back(cycle_cnt);
        name_q.push_back(name);
        exp_q.push_back(ref_model(build_req(op, rm, a, b, next_tag)));
        fpu_op    = op;
        fpu_rm    = rm;
        operand_a = a;
        operand_b = b;
        trans_id  = next_tag;
        fpu_valid = 1'b1;
        next_tag++;
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        @(posedge clk);
        #5 fpu_valid = 1'b0;
        while (exp_q.size() != 0) begin
            @(posedge clk);
            waited++;
            if (waited > WAIT_LIMIT) begin
                timeouts++;
                $display("Timeout: %0d results still outstanding", exp_q.size());
                finish_run();
            end
        end
    endtask

    // ----------------------------------------
    // Scoreboard, sampled mid cycle
    // ----------------------------------------
    always @(negedge clk) begin : compare
        fpu_rsp_t act_rsp, exp_rsp;
        string    name;
        int       sent;
        bit       timed;
        if (rst_n && out_valid) begin
            act_rsp = '{result: result, tag: out_tag, nv: nv};
            assert (exp_q.size() != 0) else begin
                proto_errs++;
                $display("Result valid while no request was outstanding");
            end
            if (exp_q.size() != 0) begin
                exp_rsp = exp_q.pop_front();
                name    = name_q.pop_front();
                sent    = sent_q.pop_front();
                timed   = timed_q.pop_front();
                assert (act_rsp == exp_rsp) else begin
                    value_errs++;
                    $display("Fail %s: expected %h tag %0d nv %b, actual %h tag %0d nv %b",
                             name, exp_rsp.result, exp_rsp.tag, exp_rsp.nv,
                             act_rsp.result, act_rsp.tag, act_rsp.nv);
                end
                assert (!timed || cycle_cnt - sent == NONCOMP_LAT) else begin
                    value_errs++;
                    $display("Fail %s latency: expected %0d, actual %0d",
                             name, NONCOMP_LAT, cycle_cnt - sent);
                end
            end
        end
    end

    // ----------------------------------------
    // Test sequence
    // ----------------------------------------
    initial begin : stimulus
        int    waited;
        fp32_t same_val;
        {flush, fpu_valid, fpu_rm, operand_a, operand_b, trans_id} = '0;
        fpu_op   = FSGNJ;
        next_tag = '0;
        waited   = 0;
        while (rst_n !== 1'b1) begin
            @(posedge clk);
            waited++;
            if (waited > WAIT_LIMIT) begin
                timeouts++;
                $display("Timeout: reset never released");
                finish_run();
            end
        end
        // Sign injection and moves
        for (int i = 0; i < 24; i++) begin
            issue(FSGNJ, rm_t'(i % 3), pick_operand(), pick_operand(), "sgnj");
        end
        for (int i = 0; i < 4; i++) begin
            issue(FSGNJ, rm_t'(3 + 4 * (i % 2)), pick_operand(), pick_operand(), "sgnj_pass");
            issue(FMV_F2X, rm_t'(i), pick_operand(), pick_operand(), "fmv_f2x");
            issue(FMV_X2F, rm_t'(i + 4), pick_operand(), pick_operand(), "fmv_x2f");
        end
        drain();
        // Min/max, random then special pairs
        for (int i = 0; i < 20; i++) begin
            issue(FMIN_MAX, rm_t'(i % 2), pick_operand(), pick_operand(), "minmax");
        end
        for (int s = 0; s < 2; s++) begin
            issue(FMIN_MAX, rm_t'(s), 32'h0000_0000, 32'h8000_0000, "minmax_zero");
            issue(FMIN_MAX, rm_t'(s), 32'h8000_0000, 32'h0000_0000, "minmax_zero");
            issue(FMIN_MAX, rm_t'(s), 32'h7FC0_0000, 32'h3F80_0000, "minmax_qnan");
            issue(FMIN_MAX, rm_t'(s), 32'hBF80_0000, 32'hFFC0_1234, "minmax_qnan");
            issue(FMIN_MAX, rm_t'(s), 32'h7FC0_0001, 32'hFFC0_0000, "minmax_two_nan");
            issue(FMIN_MAX, rm_t'(s), 32'h7F80_0001, 32'h4000_0000, "minmax_snan");
            issue(FMIN_MAX, rm_t'(s), 32'h7FC0_0000, 32'hFFA0_0000, "minmax_snan");
        end
        drain();
        // Compare, random, equal and unordered operands
        for (int i = 0; i < 24; i++) begin
            issue(FCMP, rm_t'(i % 4), pick_operand(), pick_operand(), "cmp");
        end
        for (int s = 0; s < 4; s++) begin
            same_val = pick_operand();  // Reused for A and B
            issue(FCMP, rm_t'(s), same_val, same_val, "cmp_equal");
            issue(FCMP, rm_t'(s), 32'h8000_0000, 32'h0000_0000, "cmp_zero");
            issue(FCMP, rm_t'(s), 32'h7FC0_0000, 32'h3F80_0000, "cmp_qnan");
            issue(FCMP, rm_t'(s), 32'h3F80_0000, 32'hFF80_0001, "cmp_snan");
        end
        drain();
        for (int i = 0; i < 10; i++) issue(FCLASS, 3'd0, specials[i], 32'h0, "classify");
        drain();
        // Back to back mix, then isolated sends with exact latency
        for (int i = 0; i < 30; i++) begin
            rng = xorshift(rng);
            issue(fu_op_e'(rng % 6), rm_t'(rng[10:8]), pick_operand(), pick_operand(), "b2b");
        end
        drain();
        for (int i = 0; i < 4; i++) begin
            issue(FCMP, 3'd2, pick_operand(), pick_operand(), "idle_latency");
            drain();
        end
        // Flush one cycle after a request, the result must never show up
        issue(FMIN_MAX, 3'd1, pick_operand(), pick_operand(), "flush_drop");
        @(posedge clk);
        #5;
        fpu_valid = 1'b0;
        flush     = 1'b1;
        exp_q.delete();
        name_q.delete();
        sent_q.delete();
        timed_q.delete();
        @(posedge clk);
        #5 flush = 1'b0;
        for (int i = 0; i < 3 * NONCOMP_LAT; i++) @(posedge clk);  // Stray valid hits compare
        issue(FSGNJ, 3'd1, pick_operand(), pick_operand(), "flush_after");
        drain();
        finish_run();
    end

endmodule

//--- tb/fpu_wrap_chk.sv
module fpu_wrap_chk (
    input logic clk_i,
    input logic rst_ni,
    input logic out_valid_i,  // Write back valid
    input logic ready_i,      // Token back to issue
    input logic hold_i,       // Hold buffer capture
    input logic use_hold_i,   // High only in STALL
    input logic in_ready_i    // Unit can take a request
);

    int unsigned fail_cnt;  // Read by the testbench at the end
    initial fail_cnt = 0;

    // Single item in flight, so results never come back to back
    a_valid_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
        out_valid_i |=> !out_valid_i)
        else begin
            $error("Result valid held for two cycles");
            fail_cnt++;
        end

    // Capture only when the unit turns the request away
    a_hold_busy: assert property (@(posedge clk_i) disable iff (!rst_ni)
        hold_i |-> !in_ready_i)
        else begin
            $error("Request held while unit was ready");
            fail_cnt++;
        end

    // STALL releases issue only in the cycle the unit takes the held request
    a_stall_ready: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (use_hold_i && ready_i) |-> in_ready_i)
        else begin
            $error("Ready raised in STALL with unit busy");
            fail_cnt++;
        end

endmodule

bind fpu_wrap fpu_wrap_chk i_wrap_chk (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .out_valid_i (fpu_valid_o),
    .ready_i     (fpu_ready_o),
    .hold_i      (hold_inputs),
    .use_hold_i  (use_hold),
    .in_ready_i  (in_ready)
);

//--- tb/fpu_clk_gen.sv
module fpu_clk_gen (
    output logic clk_o,
    output logic rst_no
);

    // Free running clock, period 40
    initial begin : p_clk
        clk_o = 1'b0;
        forever #20 clk_o = ~clk_o;
    end

    // Reset held low for two rising edges, released off the edge
    initial begin : p_rst
        rst_no = 1'b0;
        repeat (2) @(posedge clk_o);
        #5 rst_no = 1'b1;
    end

endmodule

//--- hdl/fpu_wrap.sv
module fpu_wrap
    import fpu_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_ni,
    input  logic      flush_i,
    // Issue side
    input  logic      fpu_valid_i,
    output logic      fpu_ready_o,
    input  fu_op_e    fpu_op_i,
    input  rm_t       fpu_rm_i,
    input  fp32_t     operand_a_i,
    input  fp32_t     operand_b_i,
    input  trans_id_t trans_id_i,
    // Write back, always ready
    output fp32_t     result_o,
    output trans_id_t fpu_trans_id_o,
    output logic      fpu_nv_o,
    output logic      fpu_valid_o
);

    fpu_req_t live_req;     // Decoded from issue fields
    fpu_req_t unit_req;     // Live or held, to the unit
    logic     in_valid;
    logic     in_ready;
    logic     hold_inputs;  // Capture into hold buffer
    logic     use_hold;     // Unit reads hold buffer
    fpu_rsp_t unit_rsp;

    // ----------------------------------------
    // Decode and protocol inversion
    // ----------------------------------------
    fpu_op_decode i_op_decode (
        .fpu_op_i    (fpu_op_i),
        .fpu_rm_i    (fpu_rm_i),
        .operand_a_i (operand_a_i),
        .operand_b_i (operand_b_i),
        .trans_id_i  (trans_id_i),
        .req_o       (live_req)
    );

    fpu_issue_fsm i_issue_fsm (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .flush_i     (flush_i),
        .fpu_valid_i (fpu_valid_i),
        .in_ready_i  (in_ready),
        .fpu_ready_o (fpu_ready_o),
        .in_valid_o  (in_valid),
        .hold_o      (hold_inputs),
        .use_hold_o  (use_hold)
    );

    fpu_hold_buffer i_hold_buffer (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .hold_i     (hold_inputs),
        .use_hold_i (use_hold),
        .live_req_i (live_req),
        .req_o      (unit_req)
    );

    // ----------------------------------------
    // Execution unit
    // ----------------------------------------
    fpu_noncomp_unit i_noncomp_unit (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .flush_i     (flush_i),
        .in_valid_i  (in_valid),
        .in_ready_o  (in_ready),
        .req_i       (unit_req),
        .rsp_o       (unit_rsp),
        .out_valid_o (fpu_valid_o)
    );

    // Split response onto the write back port
    assign result_o       = unit_rsp.result;
    assign fpu_trans_id_o = unit_rsp.tag;
    assign fpu_nv_o       = unit_rsp.nv;

endmodule

//--- hdl/fpu_noncomp_unit.sv
module fpu_noncomp_unit
    import fpu_pkg::*;
(
    input  logic     clk_i,
    input  logic     rst_ni,
    input  logic     flush_i,
    input  logic     in_valid_i,
    output logic     in_ready_o,
    input  fpu_req_t req_i,
    output fpu_rsp_t rsp_o,
    output logic     out_valid_o
);

    function automatic logic is_nan(input fp32_t x);
        return (&x[30:23]) && (|x[22:0]);
    endfunction

    // Signalling NaN has the quiet bit clear
    function automatic logic is_snan(input fp32_t x);
        return is_nan(x) && !x[22];
    endfunction

    fp32_t      a, b;
    logic       a_nan, b_nan, any_snan;
    logic       both_zero, ord_lt, cmp_eq, cmp_lt;
    logic       a_exp_max, a_exp_zero, a_man_zero;
    logic [9:0] class_mask;
    fp32_t      res_d;
    logic       nv_d;
    logic       busy, done, take;
    fpu_rsp_t   rsp_q;

    assign a        = req_i.operand_a;
    assign b        = req_i.operand_b;
    assign a_nan    = is_nan(a);
    assign b_nan    = is_nan(b);
    assign any_snan = is_snan(a) || is_snan(b);

    // ----------------------------------------
    // Ordering, NaNs excluded
    // ----------------------------------------
    assign both_zero = (a[30:0] == '0) && (b[30:0] == '0);
    // Total order with -0 below +0, negatives compare on reversed magnitude
    assign ord_lt = (a[31] != b[31]) ? a[31]
                  : (a[31] ? (b[30:0] < a[30:0]) : (a[30:0] < b[30:0]));
    assign cmp_eq = (a == b) || both_zero;  // IEEE equality, -0 == +0
    assign cmp_lt = ord_lt && !both_zero;

    // Classify A, RISC-V bit order
    assign a_exp_max     = &a[30:23];
    assign a_exp_zero    = ~|a[30:23];
    assign a_man_zero    = ~|a[22:0];
    assign class_mask[0] = a[31] && a_exp_max && a_man_zero;    // -inf
    assign class_mask[1] = a[31] && !a_exp_max && !a_exp_zero;  // -normal
    assign class_mask[2] = a[31] && a_exp_zero && !a_man_zero;
    assign class_mask[3] = a[31] && a_exp_zero && a_man_zero;   // -0
    assign class_mask[4] = !a[31] && a_exp_zero && a_man_zero;
    assign class_mask[5] = !a[31] && a_exp_zero && !a_man_zero;
    assign class_mask[6] = !a[31] && !a_exp_max && !a_exp_zero;
    assign class_mask[7] = !a[31] && a_exp_max && a_man_zero;   // +inf
    assign class_mask[8] = is_snan(a);
    assign class_mask[9] = a_nan && a[22];                      // Quiet NaN

    // ----------------------------------------
    // Result select
    // ----------------------------------------
    always_comb begin : p_result
        res_d = a;
        nv_d  = 1'b0;
        case (req_i.op)
            SGNJ: begin
                case (req_i.sub_op)
                    SGNJ_PLAIN: res_d = {b[31], a[30:0]};
                    SGNJ_NEG:   res_d = {~b[31], a[30:0]};
                    SGNJ_XOR:   res_d = {a[31] ^ b[31], a[30:0]};
                    SGNJ_PASS:  res_d = a;  // Register moves
                endcase
            end
            MINMAX: begin
                nv_d = any_snan;
                if (a_nan && b_nan) begin
                    res_d = CANON_NAN;
                end else if (a_nan) begin
                    res_d = b;  // NaN loses against a number
                end else if (b_nan) begin
                    res_d = a;
                end else begin
                    case (req_i.sub_op)
                        MM_MIN:  res_d = ord_lt ? a : b;
                        MM_MAX:  res_d = ord_lt ? b : a;
                        default: res_d = a;  // Unused codes return A
                    endcase
                end
            end
            CMP: begin
                res_d = '0;  // Unordered compares give 0
                case (req_i.sub_op)
                    CMP_LE: begin
                        res_d[0] = !(a_nan || b_nan) && (cmp_lt || cmp_eq);
                        nv_d     = a_nan || b_nan;  // Signalling compare
                    end
                    CMP_LT: begin
                        res_d[0] = !(a_nan || b_nan) && cmp_lt;
                        nv_d     = a_nan || b_nan;
                    end
                    CMP_EQ: begin
                        res_d[0] = !(a_nan || b_nan) && cmp_eq;
                        nv_d     = any_snan;        // Quiet compare
                    end
                    CMP_NONE: nv_d = 1'b0;
                endcase
            end
            CLASSIFY: res_d = {22'b0, class_mask};
            default: ;
        endcase
    end

    // Result registers, loaded on accept
    assign take = in_valid_i && in_ready_o;

    always_ff @(posedge clk_i) begin : p_rsp
        if (take) begin
            rsp_q.result <= res_d;
            rsp_q.tag    <= req_i.tag;
            rsp_q.nv     <= nv_d;
        end
    end

    fpu_latency_timer i_latency_timer (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .flush_i (flush_i),
        .start_i (take),
        .busy_o  (busy),
        .done_o  (done)
    );

    assign in_ready_o  = ~busy;  // Ready again in the valid cycle
    assign out_valid_o = done;
    assign rsp_o       = rsp_q;

endmodule

//--- hdl/fpu_latency_timer.sv
module fpu_latency_timer
    import fpu_pkg::*;
(
    input  logic clk_i,
    input  logic rst_ni,
    input  logic flush_i,
    input  logic start_i,  // Unit takes a request
    output logic busy_o,   // Still counting
    output logic done_o    // Last cycle, result valid
);

    timer_cnt_t cnt_q;

    // ----------------------------------------
    // Countdown
    // ----------------------------------------
    // Counts NONCOMP_LAT down to 0, zero means idle
    always_ff @(posedge clk_i or negedge rst_ni) begin : p_count
        if (!rst_ni) begin
            cnt_q <= '0;
        end else if (flush_i) begin
            cnt_q <= '0;                         // Drop item in flight
        end else if (start_i) begin
            cnt_q <= timer_cnt_t'(NONCOMP_LAT);  // New item, also on the done cycle
        end else if (cnt_q != '0) begin
            cnt_q <= cnt_q - timer_cnt_t'(1);
        end
    end

    assign busy_o = (cnt_q > timer_cnt_t'(1));
    assign done_o = (cnt_q == timer_cnt_t'(1));  // Unit is ready again here

endmodule

//--- hdl/fpu_hold_buffer.sv
module fpu_hold_buffer
    import fpu_pkg::*;
(
    input  logic     clk_i,
    input  logic     rst_ni,
    input  logic     hold_i,      // Load live request
    input  logic     use_hold_i,  // Select held copy
    input  fpu_req_t live_req_i,
    output fpu_req_t req_o
);

    fpu_req_t held_q;

    // ----------------------------------------
    // Hold register
    // ----------------------------------------
    // Loaded only in the cycle the unit turns a request away
    always_ff @(posedge clk_i or negedge rst_ni) begin : p_hold
        if (!rst_ni) begin
            held_q <= '0;
        end else if (hold_i) begin
            held_q <= live_req_i;
        end
    end

    // Held request while stalled, else the live one
    assign req_o = use_hold_i ? held_q : live_req_i;

endmodule

//--- hdl/fpu_issue_fsm.sv
module fpu_issue_fsm
    import fpu_pkg::*;
(
    input  logic clk_i,
    input  logic rst_ni,
    input  logic flush_i,
    input  logic fpu_valid_i,   // Request from issue
    input  logic in_ready_i,    // Unit can take a request
    output logic fpu_ready_o,   // Token back to issue
    output logic in_valid_o,    // Request to unit
    output logic hold_o,        // Capture live request
    output logic use_hold_o     // Present held request to unit
);

    fsm_state_e state_q, state_d;

    // ----------------------------------------
    // Protocol inversion, valid before ready
    // ----------------------------------------
    always_comb begin : p_issue_fsm
        fpu_ready_o = 1'b0;
        in_valid_o  = 1'b0;
        hold_o      = 1'b0;
        use_hold_o  = 1'b0;
        state_d     = state_q;

        case (state_q)
            READY: begin
                fpu_ready_o = 1'b1;         // Looks ready to issue
                in_valid_o  = fpu_valid_i;  // Live request straight through
                // Unit busy, park the request and stall issue
                if (fpu_valid_i && !in_ready_i) begin
                    fpu_ready_o = 1'b0;
                    hold_o      = 1'b1;
                    state_d     = STALL;
                end
            end
            STALL: begin
                in_valid_o = 1'b1;  // Held request pending
                use_hold_o = 1'b1;
                if (in_ready_i) begin
                    fpu_ready_o = 1'b1;  // Unit takes it this cycle
                    state_d     = READY;
                end
            end
            default: ;
        endcase

        // Flush drops any held request
        if (flush_i) state_d = READY;
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin : p_state
        if (!rst_ni) begin
            state_q <= READY;
        end else begin
            state_q <= state_d;
        end
    end

endmodule

//--- hdl/fpu_op_decode.sv
module fpu_op_decode
    import fpu_pkg::*;
(
    input  fu_op_e    fpu_op_i,
    input  rm_t       fpu_rm_i,
    input  fp32_t     operand_a_i,
    input  fp32_t     operand_b_i,
    input  trans_id_t trans_id_i,
    output fpu_req_t  req_o
);

    // ----------------------------------------
    // Issue code to unit operation
    // ----------------------------------------
    always_comb begin : p_decode
        // Operands and tag go through untouched
        req_o.operand_a = operand_a_i;
        req_o.operand_b = operand_b_i;
        req_o.tag       = trans_id_i;
        req_o.op        = SGNJ;
        req_o.sub_op    = SGNJ_PASS;

        // Top rm bit is ignored, only scalar FP32 here
        case (fpu_op_i)
            FSGNJ: begin
                req_o.op     = SGNJ;
                req_o.sub_op = fpu_rm_i[1:0];  // Plain, negated or xor
            end
            FMIN_MAX: begin
                req_o.op     = MINMAX;
                req_o.sub_op = fpu_rm_i[1:0];  // Min or max
            end
            FCMP: begin
                req_o.op     = CMP;
                req_o.sub_op = fpu_rm_i[1:0];  // le, lt, eq
            end
            FCLASS: begin
                req_o.op     = CLASSIFY;
                req_o.sub_op = fpu_rm_i[1:0];  // Don't care for classify
            end
            // Moves need no recoding, just pass A
            FMV_F2X, FMV_X2F: begin
                req_o.op     = SGNJ;
                req_o.sub_op = SGNJ_PASS;
            end
            default: begin
                req_o.op     = SGNJ;      // Unknown codes behave as a move
                req_o.sub_op = SGNJ_PASS;
            end
        endcase
    end

endmodule

//--- hdl/fpu_pkg.sv
package fpu_pkg;

    // ----------------------------------------
    // Widths and timing
    // ----------------------------------------
    localparam int FLEN          = 32;  // Scalar FP32 only
    localparam int TRANS_ID_BITS = 3;   // Scoreboard tag width
    localparam int NONCOMP_LAT   = 3;   // Cycles from accept to result

    typedef logic [FLEN-1:0]          fp32_t;
    typedef logic [TRANS_ID_BITS-1:0] trans_id_t;
    typedef logic [2:0]               rm_t;         // Rounding field, carries sub-op codes
    typedef logic [1:0]               sub_op_t;
    typedef logic [1:0]               timer_cnt_t;  // Must hold NONCOMP_LAT

    // Canonical quiet NaN, positive sign
    localparam fp32_t CANON_NAN = 32'h7FC0_0000;

    // ----------------------------------------
    // Operation encodings
    // ----------------------------------------
    // Issue side operation codes
    typedef enum logic [2:0] {
        FSGNJ,
        FMIN_MAX,
        FCMP,
        FCLASS,
        FMV_F2X,
        FMV_X2F
    } fu_op_e;

    // Operations of the execution unit
    typedef enum logic [1:0] {
        SGNJ,
        MINMAX,
        CMP,
        CLASSIFY
    } unit_op_e;

    // Sign injection sub-ops
    localparam sub_op_t SGNJ_PLAIN = 2'd0;
    localparam sub_op_t SGNJ_NEG   = 2'd1;
    localparam sub_op_t SGNJ_XOR   = 2'd2;
    localparam sub_op_t SGNJ_PASS  = 2'd3;  // Used by both moves
    // Min/max sub-ops
    localparam sub_op_t MM_MIN     = 2'd0;
    localparam sub_op_t MM_MAX     = 2'd1;
    // Compare sub-ops
    localparam sub_op_t CMP_LE     = 2'd0;
    localparam sub_op_t CMP_LT     = 2'd1;
    localparam sub_op_t CMP_EQ     = 2'd2;
    localparam sub_op_t CMP_NONE   = 2'd3;  // Always false, no flag

    // Issue side protocol inversion
    typedef enum logic {
        READY,
        STALL
    } fsm_state_e;

    // ----------------------------------------
    // Request and response
    // ----------------------------------------
    typedef struct packed {
        unit_op_e  op;
        sub_op_t   sub_op;
        fp32_t     operand_a;
        fp32_t     operand_b;
        trans_id_t tag;
    } fpu_req_t;

    typedef struct packed {
        fp32_t     result;
        trans_id_t tag;
        logic      nv;      // Invalid operation flag
    } fpu_rsp_t;

endpackage
